// File: vlog.f
common/noc_params.sv
input_port/circular_buffer.sv
input_port/input_buffer.sv
input_port/input_port.sv
verilog/vc_allocator.sv
verilog/switch_allocator.sv
verilog/crossbar.sv
verilog/router.sv
tests/router_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the router testbench with Verilator, run it and search the log for the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module router_tb -f vlog.f -o router_tb &&
./obj_dir/router_tb > sim.log 2>&1 ||
{ echo "build or run of the simulation did not complete"; exit 1; }
cat sim.log
grep -q "^TB PASSED$" sim.log && exit 0 || exit 1

// File: tests/router_tb.sv
`timescale 1ns/1ps

module router_tb import noc_params::*; ();

    localparam int MAX_PKTS = 64;
    localparam int MAX_LEN = 16;
    localparam int ROUTER_X = 2;
    localparam int ROUTER_Y = 2;
    localparam int PAD_SIZE = FLIT_DATA_SIZE - 2 * COORD_SIZE;

    logic              clk;
    logic              rst;
    flit_t             data_i [PORT_NUM];
    logic              valid_i [PORT_NUM];
    logic [VC_NUM-1:0] downstream_full_i [PORT_NUM];
    flit_t             data_o [PORT_NUM];
    logic              valid_o [PORT_NUM];
    logic [VC_NUM-1:0] is_full_o [PORT_NUM];

    logic [31:0]               rng_state;
    logic [FLIT_DATA_SIZE-1:0] exp_data [MAX_PKTS][MAX_LEN];   // head entry holds dest and id
    int                        exp_len [MAX_PKTS];
    port_t                     exp_port [MAX_PKTS];
    int                        pkt_src [MAX_PKTS];
    logic [VC_SIZE-1:0]        pkt_vc [MAX_PKTS];
    int                        tx_count [MAX_PKTS];
    int                        rx_count [MAX_PKTS];
    int                        open_pkt [PORT_NUM][VC_NUM];   // packet open on each output VC
    logic [VC_NUM-1:0]         prev_full [PORT_NUM];
    int                        pkt_count;
    int                        flits_planned;
    int                        cycles;
    int                        value_errors;
    int                        order_errors;
    int                        route_errors;
    int                        bp_errors;
    int                        lost_errors;
    int                        timeout_errors;

    router #(
        .ROUTER_X (COORD_SIZE'(ROUTER_X)),
        .ROUTER_Y (COORD_SIZE'(ROUTER_Y))
    ) UUT (
        .clk               (clk),
        .rst               (rst),
        .data_i            (data_i),
        .valid_i           (valid_i),
        .downstream_full_i (downstream_full_i),
        .data_o            (data_o),
        .valid_o           (valid_o),
        .is_full_o         (is_full_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic port_t expected_port(input int dx, input int dy);
        if (dx > ROUTER_X)
            return EAST;
        else if (dx < ROUTER_X)
            return WEST;
        else if (dy > ROUTER_Y)
            return NORTH;
        else if (dy < ROUTER_Y)
            return SOUTH;
        return LOCAL;
    endfunction

    function automatic logic all_delivered();
        for (int i = 0; i < pkt_count; i++)
        begin
            if (rx_count[i] != exp_len[i])
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic build_packet(input int src, input int vc, input int dx, input int dy,
                                input int len);
        exp_len[pkt_count]     = len;
        exp_port[pkt_count]    = expected_port(dx, dy);
        pkt_src[pkt_count]     = src;
        pkt_vc[pkt_count]      = VC_SIZE'(vc);
        tx_count[pkt_count]    = 0;
        rx_count[pkt_count]    = 0;
        exp_data[pkt_count][0] = {COORD_SIZE'(dx), COORD_SIZE'(dy), PAD_SIZE'(pkt_count)};
        for (int i = 1; i < len; i++)
            exp_data[pkt_count][i] = FLIT_DATA_SIZE'(next_random());
        flits_planned += len;
        pkt_count++;
    endtask

    task automatic send_packet(input int id);
        flit_t f;
        int    src;
        src = pkt_src[id];
        for (int i = 0; i < exp_len[id]; i++)
        begin
            f.flit_label   = (i == 0) ? HEAD : ((i == exp_len[id] - 1) ? TAIL : BODY);
            f.vc_id        = pkt_vc[id];
            f.payload.data = exp_data[id][i];
            @(negedge clk);
            while (is_full_o[src][pkt_vc[id]])   // upstream holds the flit while its VC is full
                @(negedge clk);
            @(posedge clk);
            data_i[src]  <= f;
            valid_i[src] <= 1'b1;
            tx_count[id]++;
            @(posedge clk);
            valid_i[src] <= 1'b0;
        end
    endtask

    task automatic send_five(input int base);
        fork
            send_packet(base);
            send_packet(base + 1);
            send_packet(base + 2);
            send_packet(base + 3);
            send_packet(base + 4);
        join
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (!all_delivered())
            @(posedge clk);
    endtask

    task automatic check_flit(input int o, input flit_t f);
        int          id;
        int          pos;
        flit_label_t label;
        id = open_pkt[o][f.vc_id];
        if (id < 0)
        begin
            if (f.flit_label != HEAD)
            begin
                order_errors++;
                $display("CHECK FAILED data_o[%0d].flit_label expected %h got %h",
                         o, HEAD, f.flit_label);
                return;
            end
            id = int'(f.payload.head.pad);
            if (id >= pkt_count || rx_count[id] != 0)
            begin
                order_errors++;
                $display("head on output %0d names packet %0d that was never sent or already came",
                         o, id);
                return;
            end
            assert (port_t'(o) == exp_port[id])
            else
            begin
                route_errors++;
                $display("CHECK FAILED output port of packet %0d expected %h got %h",
                         id, exp_port[id], o);
            end
            open_pkt[o][f.vc_id] = id;
        end
        pos   = rx_count[id];
        label = (pos == 0) ? HEAD : ((pos == exp_len[id] - 1) ? TAIL : BODY);
        assert (f.flit_label == label)
        else
        begin
            order_errors++;
            $display("CHECK FAILED data_o[%0d].flit_label expected %h got %h", o, label, f.flit_label);
        end
        assert (f.payload.data == exp_data[id][pos])
        else
        begin
            value_errors++;
            $display("CHECK FAILED data_o[%0d].payload expected %h got %h",
                     o, exp_data[id][pos], f.payload.data);
        end
        rx_count[id]++;
        if (rx_count[id] == exp_len[id])
            open_pkt[o][f.vc_id] = -1;
    endtask

    // flits on valid_o were granted in the previous cycle against that cycle's full levels
    always @(negedge clk)
    begin
        if (!rst)
        begin
            for (int o = 0; o < PORT_NUM; o++)
            begin
                if (valid_o[o])
                begin
                    assert (!prev_full[o][data_o[o].vc_id])
                    else
                    begin
                        bp_errors++;
                        $display("CHECK FAILED valid_o[%0d] vc_id %h while downstream_full_i %h",
                                 o, data_o[o].vc_id, prev_full[o]);
                    end
                    check_flit(o, data_o[o]);
                end
                prev_full[o] = downstream_full_i[o];
            end
        end
    end

    task automatic route_directed();
        int base;
        base = pkt_count;
        build_packet(LOCAL, 0, 4, 1, 3);   // x is settled first so this one goes east
        build_packet(NORTH, 1, 1, 3, 3);
        build_packet(SOUTH, 0, 2, 4, 3);
        build_packet(EAST, 1, 2, 0, 3);
        build_packet(WEST, 0, ROUTER_X, ROUTER_Y, 3);
        send_five(base);
        wait_drained();
    endtask

    task automatic route_random();
        int base;
        int vc;
        int dx;
        int dy;
        int len;
        repeat (4)
        begin
            base = pkt_count;
            for (int p = 0; p < PORT_NUM; p++)
            begin
                vc  = int'(next_random() % 2);
                dx  = int'(next_random() % 5);
                dy  = int'(next_random() % 5);
                len = 2 + int'(next_random() % 6);
                build_packet(p, vc, dx, dy, len);
            end
            send_five(base);
        end
        wait_drained();
    endtask

    task automatic share_output_vcs();
        int base;
        base = pkt_count;
        build_packet(LOCAL, 0, 2, 4, 6);
        build_packet(SOUTH, 1, 3, 4, 6);   // x higher, so this one leaves east instead
        build_packet(WEST, 1, 2, 3, 6);
        build_packet(EAST, 0, 2, 4, 6);
        fork
            send_packet(base);
            send_packet(base + 1);
            send_packet(base + 2);
            send_packet(base + 3);
        join
        wait_drained();
    endtask

    task automatic hold_downstream();
        int id;
        id = pkt_count;
        build_packet(WEST, 1, 3, 2, BUFFER_SIZE + 4);
        @(posedge clk);
        downstream_full_i[EAST] <= '1;
        fork
            send_packet(id);
            begin
                @(negedge clk);
                while (!is_full_o[WEST][1])
                    @(negedge clk);
                assert (tx_count[id] == BUFFER_SIZE)
                else
                begin
                    bp_errors++;
                    $display("CHECK FAILED flits written before is_full_o[%0d][1] expected %h got %h",
                             WEST, BUFFER_SIZE, tx_count[id]);
                end
                @(posedge clk);
                downstream_full_i[EAST] <= '0;
            end
        join
        wait_drained();
    endtask

    task automatic contend_one_output();
        int base;
        base = pkt_count;
        build_packet(LOCAL, 0, 0, 2, 14);
        build_packet(NORTH, 1, 0, 2, 14);
        build_packet(SOUTH, 0, 1, 2, 14);
        build_packet(EAST, 1, 0, 3, 14);
        fork
            send_packet(base);
            send_packet(base + 1);
            send_packet(base + 2);
            send_packet(base + 3);
        join
        wait_drained();
    endtask

    task automatic finish_run();
        int total;
        total = value_errors + order_errors + route_errors + bp_errors + lost_errors
              + timeout_errors;
        $display("errors: value %0d, order %0d, route %0d, backpressure %0d, lost %0d, timeout %0d",
                 value_errors, order_errors, route_errors, bp_errors, lost_errors,
                 timeout_errors);
        if (total == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    // the budget grows as packets are planned
    initial
    begin
        cycles = 0;
        while (cycles < 40 * flits_planned + 500)
        begin
            @(posedge clk);
            cycles++;
        end
        timeout_errors++;
        $display("run stopped by the timeout after %0d cycles with packets still in flight", cycles);
        for (int i = 0; i < pkt_count; i++)
        begin
            assert (rx_count[i] == exp_len[i])
            else
            begin
                lost_errors++;
                $display("packet %0d arrived with %0d of its %0d flits", i, rx_count[i], exp_len[i]);
            end
        end
        finish_run();
    end

    initial
    begin
        rst <= 1'b1;
        for (int p = 0; p < PORT_NUM; p++)
        begin
            data_i[p]            <= '0;
            valid_i[p]           <= 1'b0;
            downstream_full_i[p] <= '0;
            prev_full[p]         = '0;
            for (int v = 0; v < VC_NUM; v++)
                open_pkt[p][v] = -1;
        end
        rng_state = 32'd87615;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        for (int o = 0; o < PORT_NUM; o++)
        begin
            assert (!valid_o[o])
            else
            begin
                order_errors++;
                $display("CHECK FAILED valid_o[%0d] expected %h got %h", o, 1'b0, valid_o[o]);
            end
            assert (is_full_o[o] == '0)
            else
            begin
                bp_errors++;
                $display("CHECK FAILED is_full_o[%0d] expected %h got %h", o, 2'b00, is_full_o[o]);
            end
        end
        route_directed();
        route_random();
        share_output_vcs();
        hold_downstream();
        contend_one_output();
        finish_run();
    end

endmodule

// File: verilog/router.sv
`timescale 1ns/1ps

module router import noc_params::*; #(
    parameter logic [COORD_SIZE-1:0] ROUTER_X = '0,
    parameter logic [COORD_SIZE-1:0] ROUTER_Y = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  flit_t             data_i [PORT_NUM],
    input  logic              valid_i [PORT_NUM],
    input  logic [VC_NUM-1:0] downstream_full_i [PORT_NUM],
    output flit_t             data_o [PORT_NUM],
    output logic              valid_o [PORT_NUM],
    output logic [VC_NUM-1:0] is_full_o [PORT_NUM]
);

    flit_t              buf_data [PORT_NUM][VC_NUM];
    port_t              out_port [PORT_NUM][VC_NUM];
    logic [VC_SIZE-1:0] vc_id [PORT_NUM][VC_NUM];
    logic [VC_SIZE-1:0] vc_new [PORT_NUM][VC_NUM];
    logic [VC_NUM-1:0]  tail [PORT_NUM];
    logic [VC_NUM-1:0]  va_req [PORT_NUM];
    logic [VC_NUM-1:0]  sa_req [PORT_NUM];
    logic [VC_NUM-1:0]  vc_valid [PORT_NUM];
    logic [VC_NUM-1:0]  read [PORT_NUM];
    logic [VC_NUM-1:0]  tail_sent [PORT_NUM];
    logic               grant_valid [PORT_NUM];
    port_t              grant_port [PORT_NUM];
    logic [VC_SIZE-1:0] grant_vc [PORT_NUM];

    for (genvar p = 0; p < PORT_NUM; p++)
    begin : g_port
        input_port #(
            .ROUTER_X (ROUTER_X),
            .ROUTER_Y (ROUTER_Y)
        ) u_input_port (
            .clk        (clk),
            .rst        (rst),
            .data_i     (data_i[p]),
            .valid_i    (valid_i[p]),
            .read_i     (read[p]),
            .vc_new_i   (vc_new[p]),
            .vc_valid_i (vc_valid[p]),
            .data_o     (buf_data[p]),
            .is_full_o  (is_full_o[p]),
            .out_port_o (out_port[p]),
            .va_req_o   (va_req[p]),
            .sa_req_o   (sa_req[p])
        );

        for (genvar v = 0; v < VC_NUM; v++)
        begin : g_vc
            assign vc_id[p][v] = buf_data[p][v].vc_id;
            assign tail[p][v]  = buf_data[p][v].flit_label == TAIL;
        end
    end

    vc_allocator u_vc_allocator (
        .clk         (clk),
        .rst         (rst),
        .va_req_i    (va_req),
        .out_port_i  (out_port),
        .tail_sent_i (tail_sent),
        .vc_valid_o  (vc_valid),
        .vc_new_o    (vc_new)
    );

    switch_allocator u_switch_allocator (
        .clk               (clk),
        .rst               (rst),
        .sa_req_i          (sa_req),
        .out_port_i        (out_port),
        .vc_id_i           (vc_id),
        .tail_i            (tail),
        .downstream_full_i (downstream_full_i),
        .read_o            (read),
        .grant_valid_o     (grant_valid),
        .grant_port_o      (grant_port),
        .grant_vc_o        (grant_vc),
        .tail_sent_o       (tail_sent)
    );

    crossbar u_crossbar (
        .clk           (clk),
        .rst           (rst),
        .data_i        (buf_data),
        .grant_valid_i (grant_valid),
        .grant_port_i  (grant_port),
        .grant_vc_i    (grant_vc),
        .data_o        (data_o),
        .valid_o       (valid_o)
    );

endmodule

// File: verilog/crossbar.sv
`timescale 1ns/1ps

module crossbar import noc_params::*; (
    input  logic               clk,
    input  logic               rst,
    input  flit_t              data_i [PORT_NUM][VC_NUM],
    input  logic               grant_valid_i [PORT_NUM],
    input  port_t              grant_port_i [PORT_NUM],
    input  logic [VC_SIZE-1:0] grant_vc_i [PORT_NUM],
    output flit_t              data_o [PORT_NUM],
    output logic               valid_o [PORT_NUM]
);

    always_ff @(posedge clk)
    begin
        for (int o = 0; o < PORT_NUM; o++)
        begin
            if (rst)
                valid_o[o] <= 1'b0;
            else
                valid_o[o] <= grant_valid_i[o];
        end
    end

    // the flit register only changes on a grant so idle outputs hold their last flit
    always_ff @(posedge clk)
    begin
        for (int o = 0; o < PORT_NUM; o++)
        begin
            if (grant_valid_i[o])
                data_o[o] <= data_i[grant_port_i[o]][grant_vc_i[o]];
        end
    end

endmodule

// File: verilog/switch_allocator.sv
`timescale 1ns/1ps

module switch_allocator import noc_params::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [VC_NUM-1:0]  sa_req_i [PORT_NUM],
    input  port_t              out_port_i [PORT_NUM][VC_NUM],
    input  logic [VC_SIZE-1:0] vc_id_i [PORT_NUM][VC_NUM],
    input  logic [VC_NUM-1:0]  tail_i [PORT_NUM],
    input  logic [VC_NUM-1:0]  downstream_full_i [PORT_NUM],
    output logic [VC_NUM-1:0]  read_o [PORT_NUM],
    output logic               grant_valid_o [PORT_NUM],
    output port_t              grant_port_o [PORT_NUM],
    output logic [VC_SIZE-1:0] grant_vc_o [PORT_NUM],
    output logic [VC_NUM-1:0]  tail_sent_o [PORT_NUM]
);

    logic                 in_valid [PORT_NUM];
    logic [VC_SIZE-1:0]   in_vc [PORT_NUM];
    logic [VC_SIZE-1:0]   in_ptr [PORT_NUM];
    logic [VC_SIZE-1:0]   in_ptr_next [PORT_NUM];
    logic [PORT_SIZE-1:0] out_ptr [PORT_NUM];
    logic [PORT_SIZE-1:0] out_ptr_next [PORT_NUM];

    always_comb
    begin
        int v;
        int p;
        v = 0;
        p = 0;
        // stage one picks a VC per input, skipping VCs whose downstream VC is full
        for (int q = 0; q < PORT_NUM; q++)
        begin
            in_valid[q]    = 1'b0;
            in_vc[q]       = '0;
            read_o[q]      = '0;
            in_ptr_next[q] = in_ptr[q];
            for (int i = 0; i < VC_NUM; i++)
            begin
                v = (int'(in_ptr[q]) + i) % VC_NUM;
                if (!in_valid[q] && sa_req_i[q][v]
                        && !downstream_full_i[out_port_i[q][v]][vc_id_i[q][v]])
                begin
                    in_valid[q] = 1'b1;
                    in_vc[q]    = VC_SIZE'(v);
                end
            end
        end
        // stage two picks one input per output
        for (int o = 0; o < PORT_NUM; o++)
        begin
            grant_valid_o[o] = 1'b0;
            grant_port_o[o]  = LOCAL;
            grant_vc_o[o]    = '0;
            tail_sent_o[o]   = '0;
            out_ptr_next[o]  = out_ptr[o];
            for (int i = 0; i < PORT_NUM; i++)
            begin
                p = (int'(out_ptr[o]) + i) % PORT_NUM;
                if (!grant_valid_o[o] && in_valid[p] && out_port_i[p][in_vc[p]] == port_t'(o))
                begin
                    grant_valid_o[o] = 1'b1;
                    grant_port_o[o]  = port_t'(p);
                    grant_vc_o[o]    = in_vc[p];
                    read_o[p][in_vc[p]] = 1'b1;
                    tail_sent_o[o][vc_id_i[p][in_vc[p]]] = tail_i[p][in_vc[p]];
                    out_ptr_next[o] = PORT_SIZE'((p + 1) % PORT_NUM);
                    in_ptr_next[p]  = VC_SIZE'((int'(in_vc[p]) + 1) % VC_NUM);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int q = 0; q < PORT_NUM; q++)
        begin
            if (rst)
            begin
                in_ptr[q]  <= '0;
                out_ptr[q] <= '0;
            end
            else
            begin
                in_ptr[q]  <= in_ptr_next[q];
                out_ptr[q] <= out_ptr_next[q];
            end
        end
    end

endmodule

// File: verilog/vc_allocator.sv
`timescale 1ns/1ps

module vc_allocator import noc_params::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [VC_NUM-1:0]  va_req_i [PORT_NUM],
    input  port_t              out_port_i [PORT_NUM][VC_NUM],
    input  logic [VC_NUM-1:0]  tail_sent_i [PORT_NUM],
    output logic [VC_NUM-1:0]  vc_valid_o [PORT_NUM],
    output logic [VC_SIZE-1:0] vc_new_o [PORT_NUM][VC_NUM]
);

    logic [VC_NUM-1:0]   busy [PORT_NUM];       // per output port and downstream VC
    logic [VC_NUM-1:0]   grant_set [PORT_NUM];
    logic [VC_SIZE-1:0]  free_vc [PORT_NUM];
    logic [IVC_SIZE-1:0] rr_ptr [PORT_NUM];
    logic [IVC_SIZE-1:0] next_ptr [PORT_NUM];

    always_comb
    begin
        int   idx;
        logic found;
        idx   = 0;
        found = 1'b0;
        for (int p = 0; p < PORT_NUM; p++)
        begin
            vc_valid_o[p] = '0;
            for (int v = 0; v < VC_NUM; v++)
                vc_new_o[p][v] = '0;
        end
        for (int o = 0; o < PORT_NUM; o++)
        begin
            free_vc[o] = '0;
            for (int v = VC_NUM - 1; v >= 0; v--)
            begin
                if (!busy[o][v])
                    free_vc[o] = VC_SIZE'(v);   // lowest free index wins
            end
            grant_set[o] = '0;
            next_ptr[o]  = rr_ptr[o];
            found        = 1'b0;
            for (int i = 0; i < IVC_NUM; i++)
            begin
                idx = (int'(rr_ptr[o]) + i) % IVC_NUM;
                if (!found && busy[o] != '1 && va_req_i[idx / VC_NUM][idx % VC_NUM]
                        && out_port_i[idx / VC_NUM][idx % VC_NUM] == port_t'(o))
                begin
                    found = 1'b1;
                    vc_valid_o[idx / VC_NUM][idx % VC_NUM] = 1'b1;
                    vc_new_o[idx / VC_NUM][idx % VC_NUM]   = free_vc[o];
                    grant_set[o][free_vc[o]] = 1'b1;
                    next_ptr[o] = IVC_SIZE'((idx + 1) % IVC_NUM);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int o = 0; o < PORT_NUM; o++)
        begin
            if (rst)
            begin
                busy[o]   <= '0;
                rr_ptr[o] <= '0;
            end
            else
            begin
                busy[o]   <= (busy[o] | grant_set[o]) & ~tail_sent_i[o];
                rr_ptr[o] <= next_ptr[o];
            end
        end
    end

endmodule

// File: input_port/input_port.sv
`timescale 1ns/1ps

module input_port import noc_params::*; #(
    parameter logic [COORD_SIZE-1:0] ROUTER_X = '0,
    parameter logic [COORD_SIZE-1:0] ROUTER_Y = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  flit_t              data_i,
    input  logic               valid_i,
    input  logic [VC_NUM-1:0]  read_i,
    input  logic [VC_SIZE-1:0] vc_new_i [VC_NUM],
    input  logic [VC_NUM-1:0]  vc_valid_i,
    output flit_t              data_o [VC_NUM],
    output logic [VC_NUM-1:0]  is_full_o,
    output port_t              out_port_o [VC_NUM],
    output logic [VC_NUM-1:0]  va_req_o,
    output logic [VC_NUM-1:0]  sa_req_o
);

    logic [VC_NUM-1:0] write;
    logic [VC_NUM-1:0] is_empty;
    port_t             route [VC_NUM];

    // dimension ordered: settle x first, then y
    function automatic port_t xy_route(input flit_payload_t payload);
        port_t dir;
        if (payload.head.dest_x > ROUTER_X)
            dir = EAST;
        else if (payload.head.dest_x < ROUTER_X)
            dir = WEST;
        else if (payload.head.dest_y > ROUTER_Y)
            dir = NORTH;
        else if (payload.head.dest_y < ROUTER_Y)
            dir = SOUTH;
        else
            dir = LOCAL;
        return dir;
    endfunction

    for (genvar v = 0; v < VC_NUM; v++)
    begin : g_vc
        assign write[v] = valid_i && data_i.vc_id == VC_SIZE'(v);

        // route the incoming head, or the next packet's head once the buffer holds one
        assign route[v] = is_empty[v] ? xy_route(data_i.payload)
                                      : xy_route(data_o[v].payload);

        input_buffer u_buffer (
            .clk        (clk),
            .rst        (rst),
            .data_i     (data_i),
            .read_i     (read_i[v]),
            .write_i    (write[v]),
            .vc_new_i   (vc_new_i[v]),
            .vc_valid_i (vc_valid_i[v]),
            .out_port_i (route[v]),
            .data_o     (data_o[v]),
            .is_full_o  (is_full_o[v]),
            .is_empty_o (is_empty[v]),
            .out_port_o (out_port_o[v]),
            .va_req_o   (va_req_o[v]),
            .sa_req_o   (sa_req_o[v])
        );
    end

endmodule

// File: input_port/input_buffer.sv
`timescale 1ns/1ps

module input_buffer import noc_params::*; (
    input  logic               clk,
    input  logic               rst,
    input  flit_t              data_i,
    input  logic               read_i,
    input  logic               write_i,
    input  logic [VC_SIZE-1:0] vc_new_i,
    input  logic               vc_valid_i,
    input  port_t              out_port_i,
    output flit_t              data_o,
    output logic               is_full_o,
    output logic               is_empty_o,
    output port_t              out_port_o,
    output logic               va_req_o,
    output logic               sa_req_o
);

    typedef enum logic [1:0] {IDLE, VA, SA} state_t;

    state_t             state;
    state_t             state_next;
    logic [VC_SIZE-1:0] downstream_vc;
    logic [VC_SIZE-1:0] downstream_vc_next;
    port_t              out_port_next;
    flit_t              front_flit;
    logic               head_ready;

    circular_buffer u_fifo (
        .clk        (clk),
        .rst        (rst),
        .data_i     (data_i),
        .read_i     (read_i),
        .write_i    (write_i),
        .data_o     (front_flit),
        .is_full_o  (is_full_o),
        .is_empty_o (is_empty_o)
    );

    // a head either arrives into an empty buffer or already waits at the front
    assign head_ready = is_empty_o ? (write_i && data_i.flit_label == HEAD)
                                   : (front_flit.flit_label == HEAD);

    assign va_req_o = state == VA;
    assign sa_req_o = state == SA && !is_empty_o;

    always_comb
    begin
        data_o       = front_flit;
        data_o.vc_id = downstream_vc;   // flits leave on the VC granted downstream
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= IDLE;
            out_port_o    <= LOCAL;
            downstream_vc <= '0;
        end
        else
        begin
            state         <= state_next;
            out_port_o    <= out_port_next;
            downstream_vc <= downstream_vc_next;
        end
    end

    always_comb
    begin
        state_next         = state;
        out_port_next      = out_port_o;
        downstream_vc_next = downstream_vc;
        case (state)
            IDLE:
            begin
                if (head_ready)
                begin
                    state_next    = VA;
                    out_port_next = out_port_i;
                end
            end
            VA:
            begin
                if (vc_valid_i)
                begin
                    state_next         = SA;
                    downstream_vc_next = vc_new_i;
                end
            end
            SA:
            begin
                if (read_i && front_flit.flit_label == TAIL)
                    state_next = IDLE;
            end
            default:
                state_next = IDLE;
        endcase
    end

endmodule

// File: input_port/circular_buffer.sv
`timescale 1ns/1ps

module circular_buffer import noc_params::*; (
    input  logic  clk,
    input  logic  rst,
    input  flit_t data_i,
    input  logic  read_i,
    input  logic  write_i,
    output flit_t data_o,
    output logic  is_full_o,
    output logic  is_empty_o
);

    flit_t mem [BUFFER_SIZE];

    logic [$clog2(BUFFER_SIZE)-1:0]   rd_ptr;
    logic [$clog2(BUFFER_SIZE)-1:0]   wr_ptr;
    logic [$clog2(BUFFER_SIZE+1)-1:0] count;
    logic                             do_read;
    logic                             do_write;

    assign is_full_o  = count == BUFFER_SIZE;
    assign is_empty_o = count == 0;
    assign do_read    = read_i && !is_empty_o;
    assign do_write   = write_i && (!is_full_o || read_i);   // a full buffer accepts if it drains
    assign data_o     = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_read)
                rd_ptr <= (rd_ptr == BUFFER_SIZE - 1) ? '0 : rd_ptr + 1'b1;
            if (do_write)
                wr_ptr <= (wr_ptr == BUFFER_SIZE - 1) ? '0 : wr_ptr + 1'b1;
            if (do_write && !do_read)
                count <= count + 1'b1;
            else if (do_read && !do_write)
                count <= count - 1'b1;
        end
    end

endmodule

// File: common/noc_params.sv
package noc_params;

    localparam VC_NUM = 2;
    localparam VC_SIZE = $clog2(VC_NUM);
    localparam PORT_NUM = 5;
    localparam PORT_SIZE = $clog2(PORT_NUM);
    localparam IVC_NUM = PORT_NUM * VC_NUM;     // input VCs across the whole router
    localparam IVC_SIZE = $clog2(IVC_NUM);
    localparam BUFFER_SIZE = 8;
    localparam COORD_SIZE = 4;
    localparam FLIT_DATA_SIZE = 16;

    // the port value doubles as the index of every per-port array
    typedef enum logic [PORT_SIZE-1:0] {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

    typedef enum logic [1:0] {
        HEAD,
        BODY,
        TAIL
    } flit_label_t;

    typedef struct packed {
        logic [COORD_SIZE-1:0]                  dest_x;
        logic [COORD_SIZE-1:0]                  dest_y;
        logic [FLIT_DATA_SIZE-2*COORD_SIZE-1:0] pad;
    } head_payload_t;

    // head flits carry the destination, all other flits carry data
    typedef union packed {
        head_payload_t             head;
        logic [FLIT_DATA_SIZE-1:0] data;
    } flit_payload_t;

    typedef struct packed {
        flit_label_t        flit_label;
        logic [VC_SIZE-1:0] vc_id;
        flit_payload_t      payload;
    } flit_t;

endpackage
